/* design/mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath and address width
`define MIPS_XLEN 32

// architectural registers, $zero included
`define MIPS_NREGS 32

`define MIPS_RESET_VECTOR 32'hBFC00000 // boot rom base, first fetch
`define MIPS_HALT_ADDR 32'h00000000 // jumping here ends the run

`endif

/* design/mips_pkg.sv */
package mips_pkg;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00, // r-type, look at funct
    OP_J = 6'h02,
    OP_JAL = 6'h03,
    OP_BEQ = 6'h04,
    OP_BNE = 6'h05,
    OP_ADDIU = 6'h09,
    OP_SLTI = 6'h0A,
    OP_ANDI = 6'h0C, // zero-extended immediate
    OP_ORI = 6'h0D, // zero-extended immediate
    OP_LUI = 6'h0F,
    OP_LB = 6'h20,
    OP_LW = 6'h23,
    OP_LBU = 6'h24,
    OP_SW = 6'h2B
  } opcode_e;

  // function field of SPECIAL, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL = 6'h00,
    FN_SRL = 6'h02,
    FN_JR = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND = 6'h24,
    FN_OR = 6'h25,
    FN_XOR = 6'h26,
    FN_SLT = 6'h2A
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, // signed compare
    ALU_SLL, ALU_SRL, // shift b by shamt
    ALU_LUI // b into upper half
  } alu_op_e;

  // shaping of the loaded word before write-back
  typedef enum logic [1:0] {
    LD_WORD,
    LD_BYTE_SIGNED,
    LD_BYTE_UNSIGNED
  } load_kind_e;

endpackage

/* design/alu.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module alu (
  input logic [`MIPS_XLEN-1:0] a,
  input logic [`MIPS_XLEN-1:0] b,
  input logic [4:0] shamt,
  input mips_pkg::alu_op_e op,
  output logic [`MIPS_XLEN-1:0] result,
  output logic zero
);

  import mips_pkg::*;

  logic [`MIPS_XLEN-1:0] diff;
  logic lt_signed;

  assign diff = a - b;

  // signed less-than from the sign bits and the difference
  assign lt_signed = (a[`MIPS_XLEN-1] != b[`MIPS_XLEN-1]) ? a[`MIPS_XLEN-1] :
                     diff[`MIPS_XLEN-1];

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = diff;
      ALU_AND: result = a & b;
      ALU_OR: result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
      ALU_SLL: result = b << shamt; // rt shifted, rs unused
      ALU_SRL: result = b >> shamt; // logical, zeros in
      ALU_LUI: result = {b[15:0], 16'h0000};
      default: result = '0;
    endcase
  end

  // branch compare uses ALU_SUB, so zero means equal
  assign zero = (result == '0);

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module reg_file (
  input logic clk,
  input logic arst_n,
  input logic we,
  input logic [4:0] ra1,
  input logic [4:0] ra2,
  input logic [4:0] wa,
  input logic [`MIPS_XLEN-1:0] wd,
  output logic [`MIPS_XLEN-1:0] rd1,
  output logic [`MIPS_XLEN-1:0] rd2,
  output logic [`MIPS_XLEN-1:0] v0
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `MIPS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != 5'd0) begin // $zero is never written
      regs[wa] <= wd;
    end
  end

  // combinational read ports
  assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

  assign v0 = regs[2]; // $v0 mirrored to the top level

endmodule

/* design/controller.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module controller (
  input logic [`MIPS_XLEN-1:0] instr,
  input logic active,
  output mips_pkg::alu_op_e alu_op,
  output mips_pkg::load_kind_e load_kind,
  output logic mem_to_reg,
  output logic alu_src_imm,
  output logic reg_dst_rd,
  output logic link,
  output logic reg_write,
  output logic branch,
  output logic branch_ne,
  output logic jump,
  output logic jump_reg,
  output logic data_write,
  output logic data_read
);

  import mips_pkg::*;

  opcode_e opcode;
  funct_e funct;
  logic reg_write_dec, data_write_dec, data_read_dec; // raw decode, before the active gate

  assign opcode = opcode_e'(instr[31:26]);
  assign funct = funct_e'(instr[5:0]);

  always_comb begin
    // defaults give a nop, also for unknown opcodes
    alu_op = ALU_ADD;
    load_kind = LD_WORD;
    mem_to_reg = 1'b0;
    alu_src_imm = 1'b0;
    reg_dst_rd = 1'b0;
    link = 1'b0;
    reg_write_dec = 1'b0;
    branch = 1'b0;
    branch_ne = 1'b0;
    jump = 1'b0;
    jump_reg = 1'b0;
    data_write_dec = 1'b0;
    data_read_dec = 1'b0;
    case (opcode)
      OP_SPECIAL: begin
        reg_dst_rd = 1'b1;
        reg_write_dec = 1'b1;
        case (funct)
          FN_SLL: alu_op = ALU_SLL;
          FN_SRL: alu_op = ALU_SRL;
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND: alu_op = ALU_AND;
          FN_OR: alu_op = ALU_OR;
          FN_XOR: alu_op = ALU_XOR;
          FN_SLT: alu_op = ALU_SLT;
          FN_JR: begin
            jump_reg = 1'b1; // target comes from rs
            reg_write_dec = 1'b0;
          end
          default: reg_write_dec = 1'b0; // unknown funct, nop
        endcase
      end
      OP_J: jump = 1'b1;
      OP_JAL: begin
        jump = 1'b1;
        link = 1'b1; // pc+4 into $ra
        reg_write_dec = 1'b1;
      end
      OP_BEQ: begin
        branch = 1'b1;
        alu_op = ALU_SUB; // zero flag gives rs == rt
      end
      OP_BNE: begin
        branch = 1'b1;
        branch_ne = 1'b1;
        alu_op = ALU_SUB;
      end
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI: begin
        alu_src_imm = 1'b1;
        reg_write_dec = 1'b1;
        case (opcode)
          OP_SLTI: alu_op = ALU_SLT;
          OP_ANDI: alu_op = ALU_AND;
          OP_ORI: alu_op = ALU_OR;
          OP_LUI: alu_op = ALU_LUI;
          default: alu_op = ALU_ADD; // addiu
        endcase
      end
      OP_LB, OP_LW, OP_LBU: begin
        alu_src_imm = 1'b1; // address = rs + imm
        mem_to_reg = 1'b1;
        reg_write_dec = 1'b1;
        data_read_dec = 1'b1;
        load_kind = (opcode == OP_LB) ? LD_BYTE_SIGNED :
                    (opcode == OP_LBU) ? LD_BYTE_UNSIGNED : LD_WORD;
      end
      OP_SW: begin
        alu_src_imm = 1'b1;
        data_write_dec = 1'b1;
      end
      default: ;
    endcase
  end

  // halted cpu must not touch memory or registers
  assign reg_write = reg_write_dec & active;
  assign data_write = data_write_dec & active;
  assign data_read = data_read_dec & active;

endmodule

/* design/datapath.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module datapath (
  input logic clk,
  input logic arst_n,
  input logic clk_enable,
  input mips_pkg::alu_op_e alu_op,
  input mips_pkg::load_kind_e load_kind,
  input logic mem_to_reg,
  input logic alu_src_imm,
  input logic reg_dst_rd,
  input logic link,
  input logic reg_write,
  input logic branch,
  input logic branch_ne,
  input logic jump,
  input logic jump_reg,
  input logic [`MIPS_XLEN-1:0] instr,
  input logic [`MIPS_XLEN-1:0] data_readdata,
  output logic active,
  output logic [`MIPS_XLEN-1:0] instr_address,
  output logic [`MIPS_XLEN-1:0] data_address,
  output logic [`MIPS_XLEN-1:0] data_writedata,
  output logic [`MIPS_XLEN-1:0] register_v0
);

  import mips_pkg::*;

  logic [`MIPS_XLEN-1:0] pc, pc_plus4, pc_next;
  logic [`MIPS_XLEN-1:0] branch_target, jump_target;
  logic [`MIPS_XLEN-1:0] imm_ext, rd1, rd2, alu_b, alu_result;
  logic [`MIPS_XLEN-1:0] load_data, wb_data;
  logic [7:0] load_byte;
  logic [4:0] wb_addr;
  logic zero, imm_zext, branch_taken, commit;

  assign commit = clk_enable & active; // one instruction retires on this edge

  // pc and halt flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `MIPS_RESET_VECTOR;
      active <= 1'b1;
    end else if (commit) begin
      pc <= pc_next;
      if (pc_next == `MIPS_HALT_ADDR) active <= 1'b0; // sticky until reset
    end
  end

  assign instr_address = pc;
  assign pc_plus4 = pc + 32'd4;

  // andi/ori take the immediate unsigned, everything else sign-extends
  assign imm_zext = (opcode_e'(instr[31:26]) == OP_ANDI) ||
                    (opcode_e'(instr[31:26]) == OP_ORI);
  assign imm_ext = imm_zext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

  assign branch_target = pc_plus4 + {imm_ext[`MIPS_XLEN-3:0], 2'b00};
  assign jump_target = {pc_plus4[31:28], instr[25:0], 2'b00}; // same 256MB region
  assign branch_taken = branch & (zero ^ branch_ne); // bne inverts the equal test

  // next pc, no delay slot
  always_comb begin
    if (jump_reg) pc_next = rd1;
    else if (jump) pc_next = jump_target;
    else if (branch_taken) pc_next = branch_target;
    else pc_next = pc_plus4;
  end

  reg_file u_reg_file (
    .clk (clk),
    .arst_n (arst_n),
    .we (reg_write & commit),
    .ra1 (instr[25:21]), // rs
    .ra2 (instr[20:16]), // rt
    .wa (wb_addr),
    .wd (wb_data),
    .rd1 (rd1),
    .rd2 (rd2),
    .v0 (register_v0)
  );

  assign alu_b = alu_src_imm ? imm_ext : rd2;

  alu u_alu (
    .a (rd1),
    .b (alu_b),
    .shamt (instr[10:6]),
    .op (alu_op),
    .result (alu_result),
    .zero (zero)
  );

  assign data_address = alu_result;
  assign data_writedata = rd2; // sw stores rt

  // byte lane select, byte 0 in bits [7:0]
  always_comb begin
    case (data_address[1:0])
      2'd0: load_byte = data_readdata[7:0];
      2'd1: load_byte = data_readdata[15:8];
      2'd2: load_byte = data_readdata[23:16];
      default: load_byte = data_readdata[31:24];
    endcase
  end

  always_comb begin
    case (load_kind)
      LD_BYTE_SIGNED: load_data = {{(`MIPS_XLEN-8){load_byte[7]}}, load_byte};
      LD_BYTE_UNSIGNED: load_data = {{(`MIPS_XLEN-8){1'b0}}, load_byte};
      default: load_data = data_readdata; // lw
    endcase
  end

  // write-back target and value
  assign wb_addr = link ? 5'd31 : (reg_dst_rd ? instr[15:11] : instr[20:16]);
  assign wb_data = link ? pc_plus4 : (mem_to_reg ? load_data : alu_result);

endmodule

/* design/mips_cpu_harvard.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_cpu_harvard (
  input logic clk,
  input logic arst_n,
  input logic clk_enable, // low stalls the whole cpu
  input logic [`MIPS_XLEN-1:0] instr_readdata,
  input logic [`MIPS_XLEN-1:0] data_readdata,
  output logic active,
  output logic [`MIPS_XLEN-1:0] register_v0,
  output logic [`MIPS_XLEN-1:0] instr_address, // current pc
  output logic [`MIPS_XLEN-1:0] data_address,
  output logic [`MIPS_XLEN-1:0] data_writedata,
  output logic data_write,
  output logic data_read
);

  import mips_pkg::*;

  alu_op_e alu_op;
  load_kind_e load_kind;
  logic mem_to_reg, alu_src_imm, reg_dst_rd, link, reg_write;
  logic branch, branch_ne, jump, jump_reg;

  controller u_controller (
    .instr (instr_readdata),
    .active (active), // gates the write strobes after halt
    .alu_op (alu_op),
    .load_kind (load_kind),
    .mem_to_reg (mem_to_reg),
    .alu_src_imm (alu_src_imm),
    .reg_dst_rd (reg_dst_rd),
    .link (link),
    .reg_write (reg_write),
    .branch (branch),
    .branch_ne (branch_ne),
    .jump (jump),
    .jump_reg (jump_reg),
    .data_write (data_write),
    .data_read (data_read)
  );

  datapath u_datapath (
    .clk (clk),
    .arst_n (arst_n),
    .clk_enable (clk_enable),
    .alu_op (alu_op),
    .load_kind (load_kind),
    .mem_to_reg (mem_to_reg),
    .alu_src_imm (alu_src_imm),
    .reg_dst_rd (reg_dst_rd),
    .link (link),
    .reg_write (reg_write),
    .branch (branch),
    .branch_ne (branch_ne),
    .jump (jump),
    .jump_reg (jump_reg),
    .instr (instr_readdata),
    .data_readdata (data_readdata),
    .active (active),
    .instr_address (instr_address),
    .data_address (data_address),
    .data_writedata (data_writedata),
    .register_v0 (register_v0)
  );

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mem_model (
  input logic clk,
  input logic clk_enable,
  input logic [31:0] instr_address,
  output logic [31:0] instr_readdata,
  input logic [31:0] data_address,
  input logic [31:0] data_writedata,
  input logic data_write,
  output logic [31:0] data_readdata,
  output int write_count
);

  logic [31:0] imem [64]; // program at the reset vector
  logic [31:0] dmem [64]; // 256 bytes, upper address bits ignored
  logic [31:0] ioff;

  function automatic logic [31:0] encode_rtype(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                               logic [4:0] sa, logic [5:0] fn);
    return {6'h00, rs, rt, rd, sa, fn};
  endfunction

  function automatic logic [31:0] encode_itype(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                               logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encode_jtype(logic [5:0] op, logic [31:0] target);
    return {op, target[27:2]}; // word index inside the 256MB region
  endfunction

  initial begin
    write_count = 0;
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'h0; // sll $0,$0,0 is a nop
      dmem[i] = 32'h9E3779B9 * 32'(i + 1);
    end
    dmem[16] = 32'h12F48A7C; // word at 0x40, byte 1 is negative
    imem[0] = encode_itype(6'h09, 5'd0, 5'd8, 16'h0040); // addiu $8, $0, 0x40
    imem[1] = encode_itype(6'h09, 5'd0, 5'd9, 16'hFFFB); // addiu $9, $0, -5
    imem[2] = encode_itype(6'h09, 5'd0, 5'd10, 16'h0003); // addiu $10, $0, 3
    imem[3] = encode_rtype(5'd9, 5'd10, 5'd2, 5'd0, 6'h21); // addu $2, $9, $10
    imem[4] = encode_rtype(5'd10, 5'd9, 5'd2, 5'd0, 6'h23); // subu $2, $10, $9
    imem[5] = encode_rtype(5'd9, 5'd10, 5'd2, 5'd0, 6'h24); // and
    imem[6] = encode_rtype(5'd9, 5'd10, 5'd2, 5'd0, 6'h25); // or
    imem[7] = encode_rtype(5'd9, 5'd10, 5'd2, 5'd0, 6'h26); // xor
    imem[8] = encode_rtype(5'd9, 5'd10, 5'd2, 5'd0, 6'h2A); // slt $2, $9, $10
    imem[9] = encode_itype(6'h0A, 5'd10, 5'd2, 16'hFFFB); // slti $2, $10, -5
    imem[10] = encode_rtype(5'd0, 5'd10, 5'd2, 5'd4, 6'h00); // sll $2, $10, 4
    imem[11] = encode_rtype(5'd0, 5'd9, 5'd2, 5'd28, 6'h02); // srl $2, $9, 28
    imem[12] = encode_itype(6'h0F, 5'd0, 5'd2, 16'hBEEF); // lui $2, 0xbeef
    imem[13] = encode_itype(6'h0D, 5'd2, 5'd2, 16'h1234); // ori $2, $2, 0x1234
    imem[14] = encode_itype(6'h0C, 5'd9, 5'd2, 16'hFF0F); // andi, immediate not sign-extended
    imem[15] = encode_itype(6'h2B, 5'd8, 5'd2, 16'h0004); // sw $2, 4($8)
    imem[16] = encode_itype(6'h23, 5'd8, 5'd2, 16'h0000); // lw $2, 0($8)
    imem[17] = encode_itype(6'h20, 5'd8, 5'd2, 16'h0001); // lb $2, 1($8)
    imem[18] = encode_itype(6'h24, 5'd8, 5'd2, 16'h0001); // lbu $2, 1($8)
    imem[19] = encode_itype(6'h23, 5'd8, 5'd2, 16'h0004); // lw back the stored word
    imem[20] = encode_itype(6'h04, 5'd10, 5'd9, 16'h0001); // beq, not taken
    imem[21] = encode_itype(6'h09, 5'd0, 5'd2, 16'h0011);
    imem[22] = encode_itype(6'h04, 5'd10, 5'd10, 16'h0001); // beq forward, taken
    imem[23] = encode_itype(6'h09, 5'd0, 5'd2, 16'h0022); // skipped
    imem[24] = encode_itype(6'h05, 5'd10, 5'd10, 16'h0001); // bne, not taken
    imem[25] = encode_itype(6'h09, 5'd0, 5'd11, 16'h0002); // loop count
    imem[26] = encode_itype(6'h09, 5'd2, 5'd2, 16'h0001); // loop body
    imem[27] = encode_itype(6'h09, 5'd11, 5'd11, 16'hFFFF);
    imem[28] = encode_itype(6'h05, 5'd11, 5'd0, 16'hFFFD); // bne backward to 26
    imem[29] = encode_itype(6'h04, 5'd11, 5'd10, 16'hFFFC); // beq backward, not taken
    imem[30] = encode_jtype(6'h03, 32'hBFC00084); // jal to word 33
    imem[31] = encode_itype(6'h09, 5'd2, 5'd2, 16'h0100); // return lands here
    imem[32] = encode_jtype(6'h02, 32'hBFC0008C); // j to word 35
    imem[33] = encode_itype(6'h09, 5'd2, 5'd2, 16'h0040); // subroutine
    imem[34] = encode_rtype(5'd31, 5'd0, 5'd0, 5'd0, 6'h08); // jr $31
    imem[35] = encode_rtype(5'd0, 5'd0, 5'd0, 5'd0, 6'h08); // jr $0, halts
  end

  assign ioff = instr_address - `MIPS_RESET_VECTOR;
  assign instr_readdata = (ioff < 32'd256) ? imem[ioff[7:2]] : 32'h0; // nop outside rom
  assign data_readdata = dmem[data_address[7:2]];

  always @(posedge clk) begin
    if (data_write && clk_enable) begin // stalled edges leave memory alone
      dmem[data_address[7:2]] <= data_writedata;
      write_count <= write_count + 1;
    end
  end

endmodule

/* tb/mips_cpu_harvard_tb.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_cpu_harvard_tb;

  localparam int MAX_CYCLES = 400; // 38 commits, 4/3 for stalls, wide margin
  localparam int NSTEPS = 38;

  // commit order as word index from the reset vector, then $v0 after each commit
  int trace_idx [NSTEPS] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 18,
    19, 20, 21, 22, 24, 25, 26, 27, 28, 26, 27, 28, 29, 30, 33, 34, 31, 32, 35};
  logic [31:0] trace_v0 [NSTEPS] = '{
    32'h0, 32'h0, 32'h0, 32'hFFFFFFFE, 32'h8, 32'h3, 32'hFFFFFFFB, 32'hFFFFFFF8, 32'h1, 32'h0,
    32'h30, 32'hF, 32'hBEEF0000, 32'hBEEF1234, 32'h0000FF0B, 32'h0000FF0B, 32'h12F48A7C,
    32'hFFFFFF8A, 32'h8A, 32'h0000FF0B, 32'h0000FF0B, 32'h11, 32'h11, 32'h11, 32'h11,
    32'h12, 32'h12, 32'h12, 32'h13, 32'h13, 32'h13, 32'h13, 32'h13, 32'h53, 32'h53, 32'h153,
    32'h153, 32'h153};

  logic clk, arst_n, clk_enable;
  logic active, data_write, data_read;
  logic [31:0] instr_readdata, data_readdata, register_v0, instr_address;
  logic [31:0] data_address, data_writedata, exp_v0;
  int write_count, errors, checks, cycles, step, post_halt;
  logic done, store_stalled;

  mips_cpu_harvard u_mips_cpu_harvard (
    .clk (clk), .arst_n (arst_n), .clk_enable (clk_enable),
    .instr_readdata (instr_readdata), .data_readdata (data_readdata),
    .active (active), .register_v0 (register_v0), .instr_address (instr_address),
    .data_address (data_address), .data_writedata (data_writedata),
    .data_write (data_write), .data_read (data_read)
  );

  tb_mem_model u_mem_model (
    .clk (clk), .clk_enable (clk_enable), .instr_address (instr_address),
    .instr_readdata (instr_readdata), .data_address (data_address),
    .data_writedata (data_writedata), .data_write (data_write),
    .data_readdata (data_readdata), .write_count (write_count)
  );

  function automatic logic [31:0] pc_of(int idx);
    return `MIPS_RESET_VECTOR + 32'(idx * 4);
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  initial begin
    void'($urandom(32'h6f08cc6b));
    {errors, checks, cycles, step, post_halt} = '0;
    exp_v0 = 32'h0;
    done = 1'b0;
    store_stalled = 1'b0;
    arst_n = 1'b0;
    clk_enable = 1'b0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    while (!done) begin
      if (data_write && !store_stalled) begin
        clk_enable = 1'b0; // hold the sw on purpose once
        store_stalled = 1'b1;
      end else begin
        clk_enable = ($urandom % 4) != 0; // about 3 of 4 edges commit
      end
      @(negedge clk);
    end
    assert (write_count == 1) else begin
      errors++;
      $display("memory was written %0d times, only one store expected", write_count);
    end
    assert (store_stalled) else begin
      errors++;
      $display("no stall landed on the store, memory hold not exercised");
    end
    check_word("dmem[0x44]", u_mem_model.dmem[17], 32'h0000FF0B);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // sampled on the rising edge, before the dut updates
  always @(posedge clk) begin
    if (arst_n && !done) begin
      cycles++;
      if (step < NSTEPS) begin
        check_bit("active", active, 1'b1);
        check_word("instr_address", instr_address, pc_of(trace_idx[step])); // holds on stall
        check_word("register_v0", register_v0, exp_v0);
        check_bit("data_read", data_read,
                  (trace_idx[step] >= 16) && (trace_idx[step] <= 19)); // lw, lb, lbu, lw
        if (clk_enable) begin
          if (trace_idx[step] == 15) begin // sw $2, 4($8)
            check_bit("data_write", data_write, 1'b1);
            check_word("data_address", data_address, 32'h00000044);
            check_word("data_writedata", data_writedata, 32'h0000FF0B);
          end else begin
            check_bit("data_write", data_write, 1'b0);
          end
          exp_v0 = trace_v0[step];
          step++;
        end
      end else begin
        check_bit("active", active, 1'b0); // halted for good
        check_bit("data_write", data_write, 1'b0);
        check_bit("data_read", data_read, 1'b0);
        check_word("instr_address", instr_address, `MIPS_HALT_ADDR);
        check_word("register_v0", register_v0, 32'h00000153); // program checksum
        post_halt++;
        done = (post_halt == 4);
      end
      if (cycles >= MAX_CYCLES) begin
        $display("timeout after %0d cycles, cpu did not halt", cycles);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
      end
    end
  end

endmodule

/* list.f */
+incdir+design
design/mips_pkg.sv
design/alu.sv
design/reg_file.sv
design/controller.sv
design/datapath.sv
design/mips_cpu_harvard.sv
tb/tb_mem_model.sv
tb/mips_cpu_harvard_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then search the simulation log for the fail message
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps -f list.f \
  --top-module mips_cpu_harvard_tb -o sim > build.log 2>&1 &&
./obj_dir/sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
